// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mips_pipeline
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_step,
  input  logic      i_flush,
  input  logic      i_freeze,
  input  instr_t    i_instr,
  input  word_t     i_pc4,
  input  logic      i_wb_we,
  input  reg_addr_t i_wb_rd,
  input  word_t     i_wb_data,
  input  reg_addr_t i_dbg_reg,
  output word_t     o_dbg_reg_data,
  id_ex_if.source   id_ex,
  hazard_if.decode  hz
);

  word_t     regs [NUM_REGS];
  word_t     rs_data, rt_data;
  word_t     imm_ext, jump_target;
  reg_addr_t dest;
  alu_op_t   alu_op;
  logic      alu_src, zero_ext, is_rtype, use_link;
  logic      reg_write, mem_read, mem_write;
  logic      branch, branch_ne, jump, jump_reg, halt;
  logic      bubble;

  always_comb begin
    alu_op    = ALU_ADD;
    alu_src   = 1'b1;
    zero_ext  = 1'b0;
    is_rtype  = 1'b0;
    use_link  = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    branch_ne = 1'b0;
    jump      = 1'b0;
    jump_reg  = 1'b0;
    halt      = 1'b0;
    if (i_instr == HALT_WORD) begin
      halt = 1'b1;
    end else begin
      case (i_instr.r.opcode)
        OP_RTYPE: begin
          is_rtype  = 1'b1;
          alu_src   = 1'b0;
          reg_write = 1'b1;
          case (i_instr.r.funct)
            FUNCT_ADDU: alu_op = ALU_ADD;
            FUNCT_SUBU: alu_op = ALU_SUB;
            FUNCT_AND:  alu_op = ALU_AND;
            FUNCT_OR:   alu_op = ALU_OR;
            FUNCT_SLT:  alu_op = ALU_SLT;
            FUNCT_SLL:  alu_op = ALU_SLL;
            FUNCT_JR: begin
              reg_write = 1'b0;
              jump_reg  = 1'b1;
            end
            default: reg_write = 1'b0;  // Unsupported funct runs as nop
          endcase
        end
        OP_ADDIU: reg_write = 1'b1;
        OP_ANDI: begin
          alu_op    = ALU_AND;
          zero_ext  = 1'b1;
          reg_write = 1'b1;
        end
        OP_ORI: begin
          alu_op    = ALU_OR;
          zero_ext  = 1'b1;
          reg_write = 1'b1;
        end
        OP_LUI: begin
          alu_op    = ALU_LUI;
          reg_write = 1'b1;
        end
        OP_LW: begin
          mem_read  = 1'b1;
          reg_write = 1'b1;
        end
        OP_SW: mem_write = 1'b1;
        OP_BEQ: begin
          alu_src = 1'b0;
          branch  = 1'b1;
        end
        OP_BNE: begin
          alu_src   = 1'b0;
          branch    = 1'b1;
          branch_ne = 1'b1;
        end
        OP_J: jump = 1'b1;
        OP_JAL: begin
          alu_op    = ALU_LINK;
          jump      = 1'b1;
          use_link  = 1'b1;
          reg_write = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign dest        = use_link ? REG_LINK : (is_rtype ? i_instr.r.rd : i_instr.i.rt);
  assign imm_ext     = zero_ext ? {16'h0000, i_instr.i.imm} :
                                  {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
  // Low 26 bits of the word hold the jump index
  assign jump_target = {i_pc4[31:28], i_instr.i.rs, i_instr.i.rt, i_instr.i.imm, 2'b00};

  // Write-through covers a producer three slots ahead
  function automatic word_t rf_read(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (i_wb_we && i_wb_rd == addr) begin
      return i_wb_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = rf_read(i_instr.r.rs);
    rt_data = rf_read(i_instr.r.rt);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_step && i_wb_we && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  assign o_dbg_reg_data = regs[i_dbg_reg];
  assign hz.id_rs       = i_instr.r.rs;
  assign hz.id_rt       = i_instr.r.rt;
  assign bubble         = i_flush || hz.stall;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      id_ex.reg_write <= 1'b0;
      id_ex.mem_read  <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.branch    <= 1'b0;
      id_ex.branch_ne <= 1'b0;
      id_ex.jump      <= 1'b0;
      id_ex.jump_reg  <= 1'b0;
      id_ex.halt      <= 1'b0;
    end else if (i_step && !i_freeze) begin
      id_ex.reg_write <= !bubble && reg_write && dest != '0;
      id_ex.mem_read  <= !bubble && mem_read;
      id_ex.mem_write <= !bubble && mem_write;
      id_ex.branch    <= !bubble && branch;
      id_ex.branch_ne <= !bubble && branch_ne;
      id_ex.jump      <= !bubble && jump;
      id_ex.jump_reg  <= !bubble && jump_reg;
      id_ex.halt      <= !bubble && halt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step && !i_freeze) begin
      id_ex.op_a        <= rs_data;
      id_ex.op_b        <= rt_data;
      id_ex.imm         <= imm_ext;
      id_ex.shamt       <= i_instr.r.shamt;
      id_ex.pc4         <= i_pc4;
      id_ex.jump_target <= jump_target;
      id_ex.rs          <= i_instr.r.rs;
      id_ex.rt          <= i_instr.r.rt;
      id_ex.rd          <= dest;
      id_ex.alu_op      <= alu_op;
      id_ex.alu_src     <= alu_src;
    end
  end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_step,
  input  logic      i_freeze,
  id_ex_if.sink     id_ex,
  ex_mem_if.source  ex_mem,
  hazard_if.execute hz,
  input  word_t     i_wb_data,
  output logic      o_redirect,
  output word_t     o_target,
  output word_t     o_alu_result
);

  word_t opnd_a, opnd_b;
  word_t src_b;
  word_t alu_result;
  word_t branch_target;
  logic  operands_eq;
  logic  branch_taken;

  function automatic word_t fwd_pick(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_MEM: return ex_mem.alu_result;
      FWD_WB:  return i_wb_data;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    opnd_a = fwd_pick(hz.fwd_a, id_ex.op_a);
    opnd_b = fwd_pick(hz.fwd_b, id_ex.op_b);
  end

  assign src_b = id_ex.alu_src ? id_ex.imm : opnd_b;

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:  alu_result = opnd_a + src_b;
      ALU_SUB:  alu_result = opnd_a - src_b;
      ALU_AND:  alu_result = opnd_a & src_b;
      ALU_OR:   alu_result = opnd_a | src_b;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(opnd_a) < $signed(src_b)};
      ALU_SLL:  alu_result = src_b << id_ex.shamt;
      ALU_LUI:  alu_result = {src_b[15:0], 16'h0000};
      ALU_LINK: alu_result = id_ex.pc4;  // jal link value
      default:  alu_result = opnd_a + src_b;
    endcase
  end

  assign operands_eq   = opnd_a == opnd_b;
  assign branch_taken  = id_ex.branch && (id_ex.branch_ne ? !operands_eq : operands_eq);
  assign branch_target = id_ex.pc4 + {id_ex.imm[XLEN-3:0], 2'b00};

  assign o_redirect = branch_taken || id_ex.jump || id_ex.jump_reg;
  always_comb begin
    if (id_ex.jump_reg) begin
      o_target = opnd_a;
    end else if (id_ex.jump) begin
      o_target = id_ex.jump_target;
    end else begin
      o_target = branch_target;
    end
  end

  assign hz.ex_rs       = id_ex.rs;
  assign hz.ex_rt       = id_ex.rt;
  assign hz.ex_rd       = id_ex.rd;
  assign hz.ex_mem_read = id_ex.mem_read;
  assign hz.ex_redirect = o_redirect;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.halt      <= 1'b0;
    end else if (i_step && !i_freeze) begin
      ex_mem.reg_write <= id_ex.reg_write;
      ex_mem.mem_read  <= id_ex.mem_read;
      ex_mem.mem_write <= id_ex.mem_write;
      ex_mem.halt      <= id_ex.halt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step && !i_freeze) begin
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= opnd_b;  // Forwarded rt
      ex_mem.rd         <= id_ex.rd;
    end
  end

  assign o_alu_result = alu_result;

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_step,
  input  logic   i_stall,
  input  logic   i_flush,
  input  logic   i_freeze,
  input  logic   i_redirect,
  input  word_t  i_target,
  input  logic   i_imem_we,
  input  word_t  i_imem_addr,  // Byte address
  input  word_t  i_imem_data,
  output instr_t o_instr,
  output word_t  o_pc4,
  output word_t  o_pc
);

  word_t pc;
  word_t pc_next_seq;
  word_t fetched;
  word_t imem [IMEM_DEPTH];

  assign pc_next_seq = pc + 32'd4;
  assign fetched     = imem[pc[IMEM_AW+1:2]];

  // Debug load port, independent of stepping
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr[IMEM_AW+1:2]] <= i_imem_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= '0;
    end else if (i_step && !i_freeze) begin
      if (i_redirect) begin
        pc <= i_target;
      end else if (!i_stall) begin
        pc <= pc_next_seq;
      end
    end
  end

  // IF/ID register, the all-zero word decodes as a nop
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_instr <= '0;
    end else if (i_step && !i_freeze) begin
      if (i_flush) begin
        o_instr <= '0;
      end else if (!i_stall) begin
        o_instr <= fetched;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step && !i_freeze && !i_stall) begin
      o_pc4 <= pc_next_seq;
    end
  end

  assign o_pc = pc;

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
  hazard_if.hazard hz
);

  logic load_use;

  // Newest producer wins, r0 is never forwarded
  function automatic fwd_sel_t fwd_pick(reg_addr_t src);
    if (src == '0) begin
      return FWD_RF;
    end
    if (hz.mem_we && hz.mem_rd == src) begin
      return FWD_MEM;
    end
    if (hz.wb_we && hz.wb_rd == src) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    hz.fwd_a = fwd_pick(hz.ex_rs);
    hz.fwd_b = fwd_pick(hz.ex_rt);
  end

  // Load in execute feeding the instruction in decode
  always_comb begin
    load_use = 1'b0;
    if (hz.ex_mem_read && hz.ex_rd != '0) begin
      load_use = hz.ex_rd == hz.id_rs || hz.ex_rd == hz.id_rt;
    end
  end

  assign hz.stall  = load_use;
  assign hz.flush  = hz.ex_redirect;  // Kills IF/ID and ID/EX
  assign hz.freeze = hz.wb_halt;

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_step,
  input  logic      i_freeze,
  ex_mem_if.sink    ex_mem,
  hazard_if.memory  hz,
  input  word_t     i_dbg_addr,  // Byte address
  output word_t     o_dbg_mem_data,
  output logic      o_wb_we,
  output reg_addr_t o_wb_rd,
  output word_t     o_wb_data,
  output logic      o_wb_halt
);

  word_t dmem [DMEM_DEPTH];
  word_t load_data;
  word_t wb_load;
  word_t wb_alu;
  logic  wb_from_mem;

  assign load_data = dmem[ex_mem.alu_result[DMEM_AW+1:2]];

  always_ff @(posedge i_clk) begin
    if (i_step && !i_freeze && ex_mem.mem_write) begin
      dmem[ex_mem.alu_result[DMEM_AW+1:2]] <= ex_mem.store_data;
    end
  end

  assign o_dbg_mem_data = dmem[i_dbg_addr[DMEM_AW+1:2]];

  // MEM/WB register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_we   <= 1'b0;
      o_wb_halt <= 1'b0;
    end else if (i_step && !i_freeze) begin
      o_wb_we   <= ex_mem.reg_write;
      o_wb_halt <= ex_mem.halt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step && !i_freeze) begin
      o_wb_rd     <= ex_mem.rd;
      wb_load     <= load_data;
      wb_alu      <= ex_mem.alu_result;
      wb_from_mem <= ex_mem.mem_read;
    end
  end

  assign o_wb_data = wb_from_mem ? wb_load : wb_alu;

  assign hz.mem_rd  = ex_mem.rd;
  assign hz.mem_we  = ex_mem.reg_write;
  assign hz.wb_rd   = o_wb_rd;
  assign hz.wb_we   = o_wb_we;
  assign hz.wb_halt = o_wb_halt;

endmodule

// File: mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_step,
  input  logic      i_imem_we,
  input  word_t     i_imem_addr,
  input  word_t     i_imem_data,
  input  reg_addr_t i_dbg_reg,
  input  word_t     i_dbg_addr,
  output word_t     o_pc,
  output word_t     o_alu_result,
  output word_t     o_dbg_reg_data,
  output word_t     o_dbg_mem_data,
  output logic      o_wb_halt
);

  instr_t    if_instr;
  word_t     if_pc4;
  logic      redirect;
  word_t     target;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  hazard_if hz ();

  fetch_stage fetch_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_step     (i_step),
    .i_stall    (hz.stall),
    .i_flush    (hz.flush),
    .i_freeze   (hz.freeze),
    .i_redirect (redirect),
    .i_target   (target),
    .i_imem_we  (i_imem_we),
    .i_imem_addr(i_imem_addr),
    .i_imem_data(i_imem_data),
    .o_instr    (if_instr),
    .o_pc4      (if_pc4),
    .o_pc       (o_pc)
  );

  decode_stage decode_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_step        (i_step),
    .i_flush       (hz.flush),
    .i_freeze      (hz.freeze),
    .i_instr       (if_instr),
    .i_pc4         (if_pc4),
    .i_wb_we       (wb_we),
    .i_wb_rd       (wb_rd),
    .i_wb_data     (wb_data),
    .i_dbg_reg     (i_dbg_reg),
    .o_dbg_reg_data(o_dbg_reg_data),
    .id_ex         (id_ex.source),
    .hz            (hz.decode)
  );

  execute_stage execute_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_step      (i_step),
    .i_freeze    (hz.freeze),
    .id_ex       (id_ex.sink),
    .ex_mem      (ex_mem.source),
    .hz          (hz.execute),
    .i_wb_data   (wb_data),
    .o_redirect  (redirect),
    .o_target    (target),
    .o_alu_result(o_alu_result)
  );

  memory_stage memory_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_step        (i_step),
    .i_freeze      (hz.freeze),
    .ex_mem        (ex_mem.sink),
    .hz            (hz.memory),
    .i_dbg_addr    (i_dbg_addr),
    .o_dbg_mem_data(o_dbg_mem_data),
    .o_wb_we       (wb_we),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data),
    .o_wb_halt     (o_wb_halt)
  );

  hazard_unit hazard_i (
    .hz(hz.hazard)
  );

endmodule

// File: mips_pkg.sv
package mips_pkg;

  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 32;
  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 64;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // Primary opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // Funct codes under OP_RTYPE
  localparam logic [5:0] FUNCT_SLL  = 6'h00;
  localparam logic [5:0] FUNCT_JR   = 6'h08;
  localparam logic [5:0] FUNCT_ADDU = 6'h21;
  localparam logic [5:0] FUNCT_SUBU = 6'h23;
  localparam logic [5:0] FUNCT_AND  = 6'h24;
  localparam logic [5:0] FUNCT_OR   = 6'h25;
  localparam logic [5:0] FUNCT_SLT  = 6'h2a;

  localparam reg_addr_t REG_LINK  = 5'd31;  // jal destination
  localparam word_t     HALT_WORD = 32'hffff_ffff;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_LUI,
    ALU_LINK   // result is pc plus 4
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

// File: pipe_if.sv
`timescale 1ns/1ps

interface id_ex_if import mips_pkg::*; ();
  word_t      op_a, op_b;
  word_t      imm;
  logic [4:0] shamt;
  word_t      pc4;
  word_t      jump_target;
  reg_addr_t  rs, rt, rd;
  alu_op_t    alu_op;
  logic       alu_src;  // Immediate as operand B
  logic       reg_write, mem_read, mem_write;
  logic       branch, branch_ne, jump, jump_reg, halt;

  modport source (output op_a, op_b, imm, shamt, pc4, jump_target, rs, rt, rd, alu_op,
                  alu_src, reg_write, mem_read, mem_write, branch, branch_ne, jump,
                  jump_reg, halt);
  modport sink (input op_a, op_b, imm, shamt, pc4, jump_target, rs, rt, rd, alu_op,
                alu_src, reg_write, mem_read, mem_write, branch, branch_ne, jump,
                jump_reg, halt);
endinterface

interface ex_mem_if import mips_pkg::*; ();
  word_t     alu_result;
  word_t     store_data;
  reg_addr_t rd;
  logic      reg_write, mem_read, mem_write, halt;

  modport source (output alu_result, store_data, rd, reg_write, mem_read, mem_write, halt);
  modport sink (input alu_result, store_data, rd, reg_write, mem_read, mem_write, halt);
endinterface

interface hazard_if import mips_pkg::*; ();
  reg_addr_t id_rs, id_rt;
  reg_addr_t ex_rs, ex_rt, ex_rd;
  logic      ex_mem_read, ex_redirect;
  reg_addr_t mem_rd, wb_rd;
  logic      mem_we, wb_we, wb_halt;
  fwd_sel_t  fwd_a, fwd_b;
  logic      stall, flush, freeze;

  modport decode (output id_rs, id_rt, input stall);
  modport execute (output ex_rs, ex_rt, ex_rd, ex_mem_read, ex_redirect, input fwd_a, fwd_b);
  modport memory (output mem_rd, mem_we, wb_rd, wb_we, wb_halt);
  modport hazard (input id_rs, id_rt, ex_rs, ex_rt, ex_rd, ex_mem_read, ex_redirect,
                  mem_rd, mem_we, wb_rd, wb_we, wb_halt,
                  output fwd_a, fwd_b, stall, flush, freeze);
endinterface

// File: tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline import mips_pkg::*; ();

  localparam int RUN_LIMIT    = 300;  // Cycles allowed for one program to reach halt
  localparam int NUM_RUNS     = 7;
  localparam int SLACK        = 600;  // Program loads, resets, pauses, debug reads
  localparam int GLOBAL_LIMIT = NUM_RUNS * RUN_LIMIT + SLACK;

  logic      i_clk;
  logic      i_rst;
  logic      i_step;
  logic      i_imem_we;
  word_t     i_imem_addr;
  word_t     i_imem_data;
  reg_addr_t i_dbg_reg;
  word_t     i_dbg_addr;
  word_t     o_pc;
  word_t     o_alu_result;
  word_t     o_dbg_reg_data;
  word_t     o_dbg_mem_data;
  logic      o_wb_halt;

  word_t prog [$];
  word_t exp_regs [NUM_REGS];
  int    errors;
  int    checks;
  int    cycle_count;

  mips_pipeline dut_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_step        (i_step),
    .i_imem_we     (i_imem_we),
    .i_imem_addr   (i_imem_addr),
    .i_imem_data   (i_imem_data),
    .i_dbg_reg     (i_dbg_reg),
    .i_dbg_addr    (i_dbg_addr),
    .o_pc          (o_pc),
    .o_alu_result  (o_alu_result),
    .o_dbg_reg_data(o_dbg_reg_data),
    .o_dbg_mem_data(o_dbg_mem_data),
    .o_wb_halt     (o_wb_halt)
  );

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= GLOBAL_LIMIT) begin
      $display("Global timeout after %0d cycles, simulation stopped", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // MIPS32 instruction encoders
  function automatic word_t rtype_word(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd, logic [4:0] shamt);
    return {OP_RTYPE, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype_word(logic [5:0] op, logic [25:0] index);
    return {op, index};
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(string name, int err_start);
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  // Program plus a few halt words so fetch never runs into unloaded memory
  task automatic load_program();
    @(negedge i_clk);
    i_step = 1'b0;
    for (int k = 0; k < prog.size() + 4; k++) begin
      i_imem_we   = 1'b1;
      i_imem_addr = word_t'(k * 4);
      i_imem_data = (k < prog.size()) ? prog[k] : HALT_WORD;
      @(negedge i_clk);
    end
    i_imem_we = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge i_clk);
    i_step = 1'b0;
    i_rst  = 1'b1;
    repeat (3) @(negedge i_clk);
    i_rst = 1'b0;
  endtask

  task automatic run_to_halt();
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    i_step = 1'b1;
    while (!o_wb_halt && cycles < RUN_LIMIT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!o_wb_halt) begin
      errors++;
      $display("ERROR t=%0t program did not reach halt within %0d cycles", $time, RUN_LIMIT);
    end
  endtask

  task automatic read_reg(reg_addr_t addr, output word_t val);
    @(negedge i_clk);
    i_dbg_reg = addr;
    #1;
    val = o_dbg_reg_data;
  endtask

  task automatic read_mem(word_t addr, output word_t val);
    @(negedge i_clk);
    i_dbg_addr = addr;
    #1;
    val = o_dbg_mem_data;
  endtask

  task automatic check_regs();
    word_t val;
    for (int k = 0; k < NUM_REGS; k++) begin
      read_reg(reg_addr_t'(k), val);
      check_word($sformatf("r%0d", k), val, exp_regs[k]);
    end
  endtask

  task automatic clear_expect();
    prog.delete();
    for (int k = 0; k < NUM_REGS; k++) begin
      exp_regs[k] = '0;
    end
  endtask

  // Dependent chain with producers at distance 1, 2 and 3
  task automatic arith_setup();
    clear_expect();
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd1, 16'd5));
    prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd2, 16'd7));
    prog.push_back(rtype_word(FUNCT_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    prog.push_back(rtype_word(FUNCT_SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd5, 16'hfffd));
    prog.push_back(rtype_word(FUNCT_AND, 5'd3, 5'd5, 5'd6, 5'd0));
    prog.push_back(rtype_word(FUNCT_OR, 5'd6, 5'd5, 5'd7, 5'd0));
    prog.push_back(rtype_word(FUNCT_SLT, 5'd5, 5'd1, 5'd8, 5'd0));
    prog.push_back(rtype_word(FUNCT_SLT, 5'd1, 5'd5, 5'd9, 5'd0));
    prog.push_back(rtype_word(FUNCT_SLL, 5'd0, 5'd2, 5'd10, 5'd4));
    prog.push_back(itype_word(OP_LUI, 5'd0, 5'd11, 16'h1234));
    prog.push_back(itype_word(OP_ORI, 5'd11, 5'd12, 16'h5678));
    prog.push_back(itype_word(OP_ANDI, 5'd12, 5'd13, 16'hff0f));
    prog.push_back(rtype_word(FUNCT_ADDU, 5'd13, 5'd10, 5'd14, 5'd0));
    prog.push_back(HALT_WORD);
    exp_regs[1]  = 32'd5;
    exp_regs[2]  = exp_regs[1] + 32'd7;
    exp_regs[3]  = exp_regs[1] + exp_regs[2];
    exp_regs[4]  = exp_regs[3] - exp_regs[1];
    exp_regs[5]  = 32'hffff_fffd;  // -3 sign extended
    exp_regs[6]  = exp_regs[3] & exp_regs[5];
    exp_regs[7]  = exp_regs[6] | exp_regs[5];
    exp_regs[8]  = ($signed(exp_regs[5]) < $signed(exp_regs[1])) ? 32'd1 : 32'd0;
    exp_regs[9]  = ($signed(exp_regs[1]) < $signed(exp_regs[5])) ? 32'd1 : 32'd0;
    exp_regs[10] = exp_regs[2] << 4;
    exp_regs[11] = {16'h1234, 16'h0000};
    exp_regs[12] = exp_regs[11] | 32'h0000_5678;
    exp_regs[13] = exp_regs[12] & 32'h0000_ff0f;  // andi zero extends
    exp_regs[14] = exp_regs[13] + exp_regs[10];
  endtask

  task automatic mem_setup(logic [15:0] base);
    clear_expect();
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd1, base));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h1234));
    prog.push_back(itype_word(OP_LUI, 5'd0, 5'd3, 16'hbeef));
    prog.push_back(itype_word(OP_ORI, 5'd3, 5'd3, 16'hcafe));
    prog.push_back(itype_word(OP_SW, 5'd1, 5'd2, 16'd0));
    prog.push_back(itype_word(OP_SW, 5'd1, 5'd3, 16'd4));
    prog.push_back(itype_word(OP_LW, 5'd1, 5'd4, 16'd4));
    prog.push_back(rtype_word(FUNCT_ADDU, 5'd4, 5'd2, 5'd5, 5'd0));  // Load-use on rs
    prog.push_back(itype_word(OP_LW, 5'd1, 5'd6, 16'd0));
    prog.push_back(itype_word(OP_ADDIU, 5'd6, 5'd7, 16'd100));
    prog.push_back(itype_word(OP_SW, 5'd1, 5'd5, 16'd8));
    prog.push_back(HALT_WORD);
    exp_regs[1] = {16'h0000, base};
    exp_regs[2] = 32'h0000_1234;
    exp_regs[3] = 32'hbeef_cafe;
    exp_regs[4] = exp_regs[3];
    exp_regs[5] = exp_regs[4] + exp_regs[2];
    exp_regs[6] = exp_regs[2];
    exp_regs[7] = exp_regs[6] + 32'd100;
  endtask

  task automatic check_stores();
    word_t val;
    read_mem(exp_regs[1], val);
    check_word($sformatf("mem[%0d]", exp_regs[1]), val, exp_regs[2]);
    read_mem(exp_regs[1] + 32'd4, val);
    check_word($sformatf("mem[%0d]", exp_regs[1] + 32'd4), val, exp_regs[3]);
    read_mem(exp_regs[1] + 32'd8, val);
    check_word($sformatf("mem[%0d]", exp_regs[1] + 32'd8), val, exp_regs[5]);
  endtask

  // Markers r20 to r27 sit in flushed slots or on paths never taken
  task automatic branch_setup();
    clear_expect();
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd1, 16'd3));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd3));
    prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd2, 16'd2));     // Taken to word 5
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd20, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd21, 16'd1));
    prog.push_back(itype_word(OP_BNE, 5'd1, 5'd2, 16'd2));     // Not taken
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd3, 16'd11));
    prog.push_back(jtype_word(OP_J, 26'd10));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd22, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd23, 16'd1));
    prog.push_back(jtype_word(OP_JAL, 26'd14));                 // Word 10
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd4, 16'd22));  // Return point
    prog.push_back(HALT_WORD);
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd27, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd5, 16'd33));  // Subroutine
    prog.push_back(rtype_word(FUNCT_JR, 5'd31, 5'd0, 5'd0, 5'd0));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd25, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd26, 16'd1));
    prog.push_back(HALT_WORD);
    exp_regs[1]  = 32'd3;
    exp_regs[2]  = 32'd3;
    exp_regs[3]  = 32'd11;
    exp_regs[4]  = 32'd22;
    exp_regs[5]  = 32'd33;
    exp_regs[31] = 32'd40 + 32'd4;  // jal at byte 40
  endtask

  task automatic arithmetic_and_forwarding();
    int err_start;
    err_start = errors;
    arith_setup();
    load_program();
    apply_reset();
    run_to_halt();
    check_regs();
    report_test("test 1 arithmetic and forwarding", err_start);
  endtask

  task automatic loads_and_stores();
    int err_start;
    err_start = errors;
    mem_setup(16'h0010);
    load_program();
    apply_reset();
    run_to_halt();
    check_regs();
    check_stores();
    report_test("test 2 loads, stores and load-use", err_start);
  endtask

  task automatic control_flow();
    int err_start;
    err_start = errors;
    branch_setup();
    load_program();
    apply_reset();
    run_to_halt();
    check_regs();
    report_test("test 3 control flow", err_start);
  endtask

  // Fresh data region so the stepped run has to store everything itself
  task automatic single_stepping();
    int    err_start;
    word_t pc_hold;
    err_start = errors;
    mem_setup(16'h0040);
    load_program();
    apply_reset();
    @(negedge i_clk);
    i_step = 1'b1;
    repeat (6) @(negedge i_clk);
    i_step  = 1'b0;
    pc_hold = 32'd24;  // Six fetches in
    check_bit("o_wb_halt", o_wb_halt, 1'b0);
    repeat (40) begin
      @(negedge i_clk);
      check_word("o_pc", o_pc, pc_hold);
      // First store waits in execute with its address
      check_word("o_alu_result", o_alu_result, exp_regs[1]);
    end
    run_to_halt();
    check_regs();
    check_stores();
    apply_reset();
    run_to_halt();
    check_regs();
    report_test("test 4 single stepping", err_start);
  endtask

  task automatic halt_and_reset();
    int    err_start;
    word_t pc_hold;
    err_start = errors;
    branch_setup();
    load_program();
    apply_reset();
    run_to_halt();
    pc_hold = o_pc;
    repeat (20) begin
      @(negedge i_clk);
      check_bit("o_wb_halt", o_wb_halt, 1'b1);
      check_word("o_pc", o_pc, pc_hold);
    end
    apply_reset();
    #1;
    check_word("o_pc", o_pc, '0);
    check_bit("o_wb_halt", o_wb_halt, 1'b0);
    run_to_halt();
    check_regs();
    report_test("test 5 halt and reset", err_start);
  endtask

  initial begin
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_step      = 1'b0;
    i_imem_we   = 1'b0;
    i_imem_addr = '0;
    i_imem_data = '0;
    i_dbg_reg   = '0;
    i_dbg_addr  = '0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;

    arithmetic_and_forwarding();
    loads_and_stores();
    control_flow();
    single_stepping();
    halt_and_reset();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
mips_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_pipeline.sv
tb_mips_pipeline.sv
